// File: all.f
+incdir+.
audgen_pkg.sv
audgen_frame_timer.sv
audgen_tone_osc.sv
audgen_i2s_serializer.sv
audgen_top.sv
audgen_tb.sv

// File: audgen_tb_model.svh
// tone model and compare tasks for the tone generator testbench
// included inside the testbench module, after the DUT signals are declared

`ifndef AUDGEN_TB_MODEL_SVH
`define AUDGEN_TB_MODEL_SVH

//////////////////////////////////////////////////
// tone model
//////////////////////////////////////////////////

// word counter and square-wave level, as the pins should show them
int   model_cnt;
logic model_level;

task automatic model_reset();
  model_cnt   = 1;
  model_level = 1'b0;
endtask

// one step per channel word, docked as held at the word start
task automatic model_word_start(input logic docked_now);
  int half;
  half = docked_now ? `AUD_HALF_LOW : `AUD_HALF_BASE;
  if (model_cnt < half) begin
    model_cnt = model_cnt + 1;
  end else begin
    model_cnt   = 1;
    model_level = ~model_level;
  end
endtask

// taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic feedback;
  feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], feedback};
endfunction

// low for the first half of each bit period
function automatic logic expected_sclk(input int phase);
  return logic'(phase >= `AUD_MCLK_PER_SCLK / 2);
endfunction

// first word after reset is lrck high
function automatic logic expected_lrck(input int word);
  return logic'(word % 2 == 0);
endfunction

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic check_sclk(input string test, input logic exp, input logic act);
  if (act !== exp) begin
    report_failure($sformatf("Error: %s word %0d bit %0d sclk expected %0b actual %0b",
                             test, cur_word, cur_bit, exp, act));
  end
endtask

task automatic check_lrck(input string test, input logic exp, input logic act);
  if (act !== exp) begin
    report_failure($sformatf("Error: %s word %0d bit %0d lrck expected %0b actual %0b",
                             test, cur_word, cur_bit, exp, act));
  end
endtask

task automatic check_dac(input string test, input logic exp, input logic act);
  if (act !== exp) begin
    report_failure($sformatf("Error: %s word %0d bit %0d dac expected %0b actual %0b",
                             test, cur_word, cur_bit, exp, act));
  end
endtask

// rising sclk edges seen in one word
task automatic check_edges(input string test, input int exp, input int act);
  if (act != exp) begin
    report_failure($sformatf("Error: %s word %0d sclk rises expected %0d actual %0d",
                             test, cur_word, exp, act));
  end
endtask

// all three pins quiet
task automatic check_idle(input string test);
  check_sclk(test, 1'b0, sclk);
  check_lrck(test, 1'b0, lrck);
  check_dac(test, 1'b0, dac);
endtask

`endif

// File: audgen_tb.sv
// testbench for the i2s square-wave tone generator
// drives reset and docked, follows the pins every mclk cycle
// and compares sclk, lrck and dac against the tone model

`timescale 1ns/10ps

`include "audgen_settings.svh"

module audgen_tb;

  //////////////////////////////////////////////////
  // run setup
  //////////////////////////////////////////////////

  localparam int NUM_WORDS      = 1200;
  // docked low up to here, then held high, then random
  localparam int BASE_END_WORD  = 400;
  localparam int DOCK_END_WORD  = 800;
  localparam int DOCK_PICK_BIT  = 16;
  localparam int RESET_CYCLES   = 3;
  localparam int CLK_HALF_NS    = 10;
  // divider up to the first strobe, then two register stages
  localparam int LEAD_IN_CYCLES = `AUD_MCLK_PER_SCLK / 2 + 2;
  localparam int WORD_CYCLES    = `AUD_BITS_PER_WORD * `AUD_MCLK_PER_SCLK;
  localparam int TIMEOUT_CYCLES = NUM_WORDS * WORD_CYCLES + 1000;
  localparam logic [31:0] LFSR_SEED = 32'h6e2d_425d;

  logic audgen_mclk = 1'b0;
  logic reset_n;
  logic docked;
  logic sclk;
  logic lrck;
  logic dac;

  int          errors      = 0;
  int          cycle_count = 0;
  int          cur_word    = 0;
  int          cur_bit     = 0;
  logic [31:0] lfsr_state;

  // print the error line and stop
  task automatic report_failure(input string line);
    errors = errors + 1;
    $display("%s", line);
    $display("Verification failed");
    $fatal(1, "stopped at the first failure");
  endtask

  `include "audgen_tb_model.svh"

  //////////////////////////////////////////////////
  // clock, DUT, timeout
  //////////////////////////////////////////////////

  always #CLK_HALF_NS audgen_mclk = ~audgen_mclk;

  audgen_top audgen_top_inst (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .docked      (docked),
    .sclk        (sclk),
    .lrck        (lrck),
    .dac         (dac)
  );

  always @(posedge audgen_mclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("the run timed out after %0d cycles without finishing",
                               cycle_count));
    end
  end

  // docked value for the given word
  task automatic pick_docked(input int word, output logic value);
    if (word < BASE_END_WORD) begin
      value = 1'b0;
    end else if (word < DOCK_END_WORD) begin
      value = 1'b1;
    end else begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = lfsr_state[0];
    end
  endtask

  function automatic string pitch_test(input int word);
    return (word < BASE_END_WORD) ? "base_pitch" : "docked_octave";
  endfunction

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin : main_seq
    logic prev_sclk;
    logic next_dock;
    int   rises;
    reset_n    = 1'b0;
    docked     = 1'b0;
    lfsr_state = LFSR_SEED;
    prev_sclk  = 1'b0;
    model_reset();
    // pins quiet while reset is low
    repeat (RESET_CYCLES - 1) begin
      @(negedge audgen_mclk);
      check_idle("reset");
    end
    @(posedge audgen_mclk);
    reset_n <= 1'b1;
    // still quiet until the first strobe reaches the pins
    repeat (LEAD_IN_CYCLES) begin
      @(negedge audgen_mclk);
      check_idle("reset");
    end
    for (int w = 0; w < NUM_WORDS; w++) begin
      cur_word = w;
      rises    = 0;
      model_word_start(docked);
      for (int b = 0; b < `AUD_BITS_PER_WORD; b++) begin
        cur_bit = b;
        for (int j = 0; j < `AUD_MCLK_PER_SCLK; j++) begin
          @(posedge audgen_mclk);
          // new docked value, seen at the next word start
          if (b == DOCK_PICK_BIT && j == 0) begin
            pick_docked(w + 1, next_dock);
            docked <= next_dock;
          end
          @(negedge audgen_mclk);
          check_sclk("bit_clock", expected_sclk(j), sclk);
          check_lrck("word_framing", expected_lrck(w), lrck);
          if (b < `AUD_LEAD_ZERO_BITS) begin
            check_dac("lead_zero", 1'b0, dac);
          end else begin
            check_dac(pitch_test(w), model_level, dac);
          end
          if (!prev_sclk && sclk) begin
            rises = rises + 1;
          end
          prev_sclk = sclk;
        end
      end
      // one rise per bit
      check_edges("bit_clock", `AUD_BITS_PER_WORD, rises);
    end
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: audgen_top.sv
// top level of the i2s square-wave tone generator
// frame timer -> tone oscillator -> serializer, all on audgen_mclk
// docked drops the tone by one octave

`timescale 1ns/10ps

module audgen_top (
  input  logic audgen_mclk,
  input  logic reset_n,
  input  logic docked,
  output logic sclk,
  output logic lrck,
  output logic dac
);

  import audgen_pkg::*;

  //////////////////////////////////////////////////
  // stage links
  //////////////////////////////////////////////////

  // bit strobe with position, timer to oscillator
  bit_strobe_t bits;

  // bit strobe with tone level, oscillator to serializer
  serial_bit_t serial;

  //////////////////////////////////////////////////
  // stages
  //////////////////////////////////////////////////

  // bit clock divider, bit index, word clock
  audgen_frame_timer audgen_frame_timer_inst (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .bits        (bits)
  );

  // word counter and square-wave level
  audgen_tone_osc audgen_tone_osc_inst (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .docked      (docked),
    .bits        (bits),
    .serial      (serial)
  );

  // i2s pins
  audgen_i2s_serializer audgen_i2s_serializer_inst (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .serial      (serial),
    .sclk        (sclk),
    .lrck        (lrck),
    .dac         (dac)
  );

endmodule

// File: audgen_i2s_serializer.sv
// last stage of the tone generator
// registers the i2s pins sclk, lrck and dac from the oscillator strobes
// leading bits of each word go out as zero

`timescale 1ns/10ps

`include "audgen_settings.svh"

module audgen_i2s_serializer (
  input  logic                    audgen_mclk,
  input  logic                    reset_n,
  input  audgen_pkg::serial_bit_t serial,
  output logic                    sclk,
  output logic                    lrck,
  output logic                    dac
);

  import audgen_pkg::*;

  //////////////////////////////////////////////////
  // constants
  //////////////////////////////////////////////////

  localparam bit_idx_t LEAD = bit_idx_t'(`AUD_LEAD_ZERO_BITS);

  // mclk cycles sclk stays low after each fall
  localparam int SCLK_LOW = `AUD_MCLK_PER_SCLK / 2;

  logic [SCLK_LOW-1:0] strobe_sr;
  logic                sclk_rise;
  logic                dac_next;
  bit_idx_t            bit_q;

  // strobe delayed by the low time, brings sclk back up
  assign sclk_rise = strobe_sr[SCLK_LOW-1];

  // zeros in front, then the tone level
  assign dac_next = (serial.bit_index < LEAD) ? 1'b0 : serial.level;

  //////////////////////////////////////////////////
  // pins
  //////////////////////////////////////////////////

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      strobe_sr <= '0;
      sclk      <= 1'b0;
      lrck      <= 1'b0;
      dac       <= 1'b0;
      bit_q     <= '0;
    end else begin
      strobe_sr <= (strobe_sr << 1) | SCLK_LOW'(serial.strobe);
      if (serial.strobe) begin
        // falling sclk, data and word clock change here only
        sclk  <= 1'b0;
        lrck  <= serial.lrck;
        dac   <= dac_next;
        bit_q <= serial.bit_index;
      end else if (sclk_rise) begin
        // receiver samples on this edge
        sclk <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // whole bit period of a leading bit is zero, not just the load cycle
  a_lead_zero : assert property (
    @(posedge audgen_mclk) disable iff (!reset_n)
    (bit_q < LEAD) |-> !dac
  );

endmodule

// File: audgen_tone_osc.sv
// second stage of the tone generator
// counts channel words and flips the square-wave level every half-period
// docked picks the octave at each word start

`timescale 1ns/10ps

`include "audgen_settings.svh"

module audgen_tone_osc (
  input  logic                    audgen_mclk,
  input  logic                    reset_n,
  input  logic                    docked,
  input  audgen_pkg::bit_strobe_t bits,
  output audgen_pkg::serial_bit_t serial
);

  import audgen_pkg::*;

  //////////////////////////////////////////////////
  // half-periods in words
  //////////////////////////////////////////////////

  localparam osc_count_t HALF_BASE = osc_count_t'(`AUD_HALF_BASE);
  localparam osc_count_t HALF_LOW  = osc_count_t'(`AUD_HALF_LOW);

  octave_t     octave_sel;
  octave_t     octave_q;
  osc_count_t  half_sel;
  osc_count_t  osc_cnt;
  logic        word_tick;
  logic        wrap;
  logic        level_q;
  logic        level_next;
  serial_bit_t serial_q;

  // octave from docked as it stands at this word start
  assign octave_sel = docked ? OCTAVE_LOW : OCTAVE_BASE;
  assign half_sel   = (octave_sel == OCTAVE_LOW) ? HALF_LOW : HALF_BASE;

  // one tick per channel word
  assign word_tick = bits.strobe & bits.word_start;

  // count reached the half-period
  assign wrap = word_tick & (osc_cnt >= half_sel);

  assign level_next = wrap ? ~level_q : level_q;

  //////////////////////////////////////////////////
  // word counter and level
  //////////////////////////////////////////////////

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      octave_q <= OCTAVE_BASE;
      osc_cnt  <= osc_count_t'(1);
      level_q  <= 1'b0;
    end else begin
      level_q <= level_next;
      if (word_tick) begin
        octave_q <= octave_sel;
        // count restarts from 1 at the half-period
        if (wrap) begin
          osc_cnt <= osc_count_t'(1);
        end else begin
          osc_cnt <= osc_cnt + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // hand off to the serializer
  //////////////////////////////////////////////////

  // strobe fields delayed one cycle with the new level attached
  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      serial_q <= '0;
    end else begin
      serial_q.strobe <= bits.strobe;
      if (bits.strobe) begin
        serial_q.bit_index <= bits.bit_index;
        serial_q.lrck      <= bits.lrck;
        serial_q.level     <= level_next;
      end
    end
  end

  assign serial = serial_q;

  // counter stays inside the half-period picked at the last word start
  a_cnt_in_range : assert property (
    @(posedge audgen_mclk) disable iff (!reset_n)
    (osc_cnt != '0) && (osc_cnt <= ((octave_q == OCTAVE_LOW) ? HALF_LOW : HALF_BASE))
  );

endmodule

// File: audgen_frame_timer.sv
// first stage of the tone generator
// divides mclk down to the bit clock and tracks bit and word position
// one strobe per bit clock, in the cycle after the internal bit clock falls

`timescale 1ns/10ps

`include "audgen_settings.svh"

module audgen_frame_timer (
  input  logic                    audgen_mclk,
  input  logic                    reset_n,
  output audgen_pkg::bit_strobe_t bits
);

  import audgen_pkg::*;

  //////////////////////////////////////////////////
  // constants
  //////////////////////////////////////////////////

  localparam int DIV_W = $clog2(`AUD_MCLK_PER_SCLK);
  // last divider count before wrap
  localparam int unsigned DIV_LAST = `AUD_MCLK_PER_SCLK - 1;
  // bit clock high for the first half of the divider range
  localparam int unsigned DIV_HALF = `AUD_MCLK_PER_SCLK / 2;
  localparam bit_idx_t IDX_LAST = bit_idx_t'(`AUD_BITS_PER_WORD - 1);

  //////////////////////////////////////////////////
  // divider and bit clock
  //////////////////////////////////////////////////

  logic [DIV_W-1:0] div_q;
  logic [DIV_W-1:0] div_next;
  logic             bclk;
  logic             bclk_next;
  logic             bclk_fall;
  bit_idx_t         idx_next;
  logic             lrck_next;
  bit_strobe_t      bits_q;

  // 0 .. DIV_LAST then wrap
  assign div_next = (div_q == DIV_W'(DIV_LAST)) ? '0 : div_q + 1'b1;

  // internal bit clock, high during counts 0 and 1
  assign bclk      = (div_q < DIV_W'(DIV_HALF));
  assign bclk_next = (div_next < DIV_W'(DIV_HALF));

  // bit clock about to fall, divider going 1 -> 2
  assign bclk_fall = bclk & ~bclk_next;

  //////////////////////////////////////////////////
  // bit and word position
  //////////////////////////////////////////////////

  // index wraps at the end of every word
  assign idx_next = (bits_q.bit_index == IDX_LAST) ? '0 : bits_q.bit_index + 1'b1;

  // word clock flips on each wrap
  assign lrck_next = (bits_q.bit_index == IDX_LAST) ? ~bits_q.lrck : bits_q.lrck;

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      div_q <= '0;
      // index parked on the last bit so the first strobe starts a word
      bits_q <= '{strobe: 1'b0, bit_index: IDX_LAST, word_start: 1'b0, lrck: 1'b0};
    end else begin
      div_q         <= div_next;
      bits_q.strobe <= bclk_fall;
      if (bclk_fall) begin
        bits_q.bit_index  <= idx_next;
        bits_q.word_start <= (idx_next == '0);
        bits_q.lrck       <= lrck_next;
      end
    end
  end

  assign bits = bits_q;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // one strobe per bit clock period, never closer or further apart
  a_strobe_spacing : assert property (
    @(posedge audgen_mclk) disable iff (!reset_n)
    bits_q.strobe |=> (!bits_q.strobe)[*DIV_LAST] ##1 bits_q.strobe
  );

  // word clock only moves at a word boundary
  a_lrck_on_word_start : assert property (
    @(posedge audgen_mclk) disable iff (!reset_n)
    $changed(bits_q.lrck) |-> (bits_q.strobe && bits_q.word_start)
  );

endmodule

// File: audgen_pkg.sv
// shared types of the tone generator pipeline
// the stage-to-stage structs and the octave select live here

`include "audgen_settings.svh"

package audgen_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // bit position within one channel word
  localparam int BIT_IDX_W = $clog2(`AUD_BITS_PER_WORD);

  typedef logic [BIT_IDX_W-1:0] bit_idx_t;

  // word counter of the oscillator
  typedef logic [`AUD_OSC_W-1:0] osc_count_t;

  //////////////////////////////////////////////////
  // octave select
  //////////////////////////////////////////////////

  // base pitch undocked, one octave lower docked
  typedef enum logic {
    OCTAVE_BASE,
    OCTAVE_LOW
  } octave_t;

  //////////////////////////////////////////////////
  // pipeline structs
  //////////////////////////////////////////////////

  // frame timer to tone oscillator
  // payload fields only valid while strobe is high
  typedef struct packed {
    logic     strobe;
    bit_idx_t bit_index;
    logic     word_start;
    logic     lrck;
  } bit_strobe_t;

  // tone oscillator to serializer
  typedef struct packed {
    logic     strobe;
    bit_idx_t bit_index;
    logic     lrck;
    logic     level;
  } serial_bit_t;

endpackage

// File: audgen_settings.svh
// constants for the i2s square-wave tone generator
// included by the package and by every stage that needs a ratio or a length

`ifndef AUDGEN_SETTINGS_SVH
`define AUDGEN_SETTINGS_SVH

//////////////////////////////////////////////////
// bit clock
//////////////////////////////////////////////////

// mclk cycles per sclk period
`define AUD_MCLK_PER_SCLK 4

// bits in one channel word, left or right
`define AUD_BITS_PER_WORD 32

// zero bits in front of the tone level
`define AUD_LEAD_ZERO_BITS 4

//////////////////////////////////////////////////
// tone
//////////////////////////////////////////////////

// words per half-period, base pitch and one octave down
`define AUD_HALF_BASE 109
`define AUD_HALF_LOW 218

// word counter width, must hold AUD_HALF_LOW
`define AUD_OSC_W 8

`endif
